// File: sources.f
+incdir+verilog
verilog/nes_pad_pkg.sv
verilog/nes_pad_scanner.sv
verilog/button_release_tracker.sv
verilog/release_event_queue.sv
verilog/nes_pad_top.sv
verification/nes_pad_device.sv
verification/nes_pad_tb.sv

// File: Bender.yml
package:
  name: nes_pad

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nes_pad_pkg.sv
      - verilog/nes_pad_scanner.sv
      - verilog/button_release_tracker.sv
      - verilog/release_event_queue.sv
      - verilog/nes_pad_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/nes_pad_device.sv
      - verification/nes_pad_tb.sv

// File: verification/nes_pad_tb.sv
// one pad and one host; a frame is about 5100 clk cycles, so the full run is close to 2M cycles
`include "nes_pad_config.svh"

module nes_pad_tb;

	localparam int frame_cycles = `NES_LATCH_CYCLES + 15 * `NES_HALF_BIT_CYCLES;

	logic                        clk = 1'b0;
	logic                        reset;
	logic                        data;
	logic                        latch;
	logic                        nes_clk;
	logic                        req;
	logic                        ack;
	nes_pad_pkg::buttons_t       buttons;
	nes_pad_pkg::buttons_t       pad_vec;    // what the pad reports this frame
	nes_pad_pkg::release_event_t evt;

	// reference state
	nes_pad_pkg::release_event_t exp_q[$];   // events the host should see in order
	nes_pad_pkg::release_event_t held_evt[8];
	logic [`NES_HOLD_BITS-1:0]   hold_cnt[8];
	bit                          pend[8];    // tracker still owns an event
	bit                          slot_busy;  // queue stuck on an unanswered req
	bit                          hold_ack;   // host ignores req
	bit                          scan_started;
	logic [7:0]                  prev_vec;   // vector of the frame being scanned
	int                          frames_done;
	int                          ack_delay;

	// pin timing as seen once per cycle
	int                          latch_len;         // latch high samples in the current pulse
	bit                          first_latch_done;  // the short latch after reset is behind us
	int                          clk_pulses;        // nes_clk pulses since the last frame start
	int                          clk_high;          // nes_clk high samples since the last frame start
	logic                        nes_clk_d;

	always #4 clk = ~clk;

	nes_pad_top u_dut (
		.clk     (clk),
		.reset   (reset),
		.data    (data),
		.latch   (latch),
		.nes_clk (nes_clk),
		.buttons (buttons),
		.req     (req),
		.evt     (evt),
		.ack     (ack)
	);

	nes_pad_device u_pad (
		.latch   (latch),
		.nes_clk (nes_clk),
		.buttons (pad_vec),
		.data    (data)
	);

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	// latch width per pulse, nes_clk edges and high time per frame
	task automatic track_pins();
		if (latch)
			latch_len++;
		else if (latch_len != 0)
		begin
			if (first_latch_done)  // latch right after reset is one cycle short
			begin
				assert (latch_len == `NES_LATCH_CYCLES)
				else
					stop_with_error($sformatf(
						"mismatch at %0t: latch width expected %0d got %0d",
						$time, `NES_LATCH_CYCLES, latch_len));
			end
			first_latch_done = 1'b1;
			latch_len        = 0;
		end
		if (nes_clk)
			clk_high++;
		if (nes_clk && !nes_clk_d)
			clk_pulses++;
		nes_clk_d = nes_clk;
	endtask

	// host side of req/ack run once per cycle
	task automatic serve_host();
		if (ack)
		begin
			if (!req)
				ack = 1'b0;  // last phase
		end
		else if (req && !hold_ack)
		begin
			if (ack_delay < 0)
				ack_delay = $urandom_range(20, 1);
			ack_delay--;
			if (ack_delay == 0)
			begin
				assert (exp_q.size() > 0)
				else
					stop_with_error($sformatf("event for button %0d arrived with none expected",
						evt.button));
				assert (evt == exp_q[0])
				else
					stop_with_error($sformatf(
						"mismatch at %0t: evt expected button %0d hold %0d, got button %0d hold %0d",
						$time, exp_q[0].button, exp_q[0].hold, evt.button, evt.hold));
				void'(exp_q.pop_front());
				ack       = 1'b1;
				ack_delay = -1;
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;  // inputs and checks just after the edge
		track_pins();
		serve_host();
	endtask

	task automatic wait_latch(input logic level);
		int n;
		n = 0;
		while (latch !== level)
		begin
			next_cycle();
			n++;
			assert (n < 2 * frame_cycles)
			else
				stop_with_error($sformatf("timeout waiting for latch to go to %0b", level));
		end
	endtask

	// tracker and queue rules at one frame_done
	task automatic model_frame(input logic [7:0] vec);
		frames_done++;
		if (frames_done > `NES_ARM_FRAMES)  // first frames never tracked
		begin
			for (int b = 0; b < 8; b++)
			begin
				if (vec[b])
				begin
					if (hold_cnt[b] != '1)
						hold_cnt[b]++;  // saturates
				end
				else if (hold_cnt[b] != '0)
				begin
					if (!pend[b])  // else this release is lost
					begin
						pend[b]            = 1'b1;
						held_evt[b].button = nes_pad_pkg::button_idx_t'(b);
						held_evt[b].hold   = hold_cnt[b];
					end
					hold_cnt[b] = '0;
				end
			end
		end
		if (!hold_ack)
			slot_busy = 1'b0;
		for (int b = 0; b < 8; b++)  // lowest button first
		begin
			if (pend[b] && !slot_busy)
			begin
				exp_q.push_back(held_evt[b]);
				pend[b]   = 1'b0;
				slot_busy = hold_ack;  // only one gets out while ack is held low
			end
		end
	endtask

	// vec goes to the pad during the latch of one scan frame
	task automatic run_frame(input logic [7:0] vec, input bit hold);
		wait_latch(1'b1);
		assert (buttons == prev_vec)
		else
			stop_with_error($sformatf("mismatch at %0t: buttons expected %h got %h",
				$time, prev_vec, buttons));
		hold_ack = hold;
		if (scan_started)  // frame_done on this same edge
		begin
			assert (clk_pulses == `NES_NUM_BUTTONS - 1)
			else
				stop_with_error($sformatf("mismatch at %0t: nes_clk pulses expected %0d got %0d",
					$time, `NES_NUM_BUTTONS - 1, clk_pulses));
			assert (clk_high == (`NES_NUM_BUTTONS - 1) * `NES_HALF_BIT_CYCLES)
			else
				stop_with_error($sformatf(
					"mismatch at %0t: nes_clk high cycles expected %0d got %0d",
					$time, (`NES_NUM_BUTTONS - 1) * `NES_HALF_BIT_CYCLES, clk_high));
			model_frame(prev_vec);
		end
		clk_pulses   = 0;
		clk_high     = 0;
		scan_started = 1'b1;
		pad_vec      = nes_pad_pkg::buttons_t'(vec);
		prev_vec     = vec;
		wait_latch(1'b0);
	endtask

	function automatic logic [7:0] next_vec(input logic [7:0] cur, input int odds);
		logic [7:0] nv;
		nv = cur;
		for (int b = 0; b < 8; b++)
		begin
			if ($urandom_range(odds - 1, 0) == 0)
				nv[b] = ~nv[b];  // toggle one button in odds
		end
		return nv;
	endfunction

	initial
	begin
		logic [7:0] v;
		int         lh;
		int         n;
		void'($urandom(70700));
		reset            = 1'b1;
		ack              = 1'b0;
		pad_vec          = '0;
		prev_vec         = '0;
		hold_ack         = 1'b0;
		slot_busy        = 1'b0;
		scan_started     = 1'b0;
		frames_done      = 0;
		ack_delay        = -1;
		latch_len        = 0;
		first_latch_done = 1'b0;
		clk_pulses       = 0;
		clk_high         = 0;
		nes_clk_d        = 1'b0;
		for (int b = 0; b < 8; b++)
		begin
			hold_cnt[b] = '0;
			pend[b]     = 1'b0;
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		run_frame(8'($urandom_range(255, 1)), 1'b0);  // pressed before arming
		run_frame(8'h00, 1'b0);                       // released before arming

		v = '0;
		repeat (40)
		begin
			v = next_vec(v, 4);
			run_frame(v, 1'b0);
		end

		// everything let go in one frame
		repeat (3) run_frame(8'hff, 1'b0);
		run_frame(8'h00, 1'b0);
		run_frame(8'h00, 1'b0);

		// host stalls while trackers fill up and drop releases
		v = '0;
		repeat (12)
		begin
			v = next_vec(v, 2);
			run_frame(v, 1'b1);
		end
		run_frame(8'h00, 1'b0);  // host answers again and the backlog drains

		// long hold on one button
		lh = $urandom_range(7, 0);
		v  = '0;
		v[lh] = 1'b1;
		repeat (300) run_frame(v, 1'b0);
		repeat (3) run_frame(8'h00, 1'b0);

		n = 0;
		while (exp_q.size() != 0 || req || ack)
		begin
			next_cycle();
			n++;
			assert (n < frame_cycles)
			else
				stop_with_error($sformatf("timeout, %0d expected events never reached the host",
					exp_q.size()));
		end
		repeat (2) run_frame(8'h00, 1'b0);  // room for a stray event to show up

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: verification/nes_pad_device.sv
// behavioral pad like a 4021 shift register; reads high (released) once all eight bits are out
module nes_pad_device (
	input  logic                  latch,
	input  logic                  nes_clk,
	input  nes_pad_pkg::buttons_t buttons,  // 1 = pressed, set by the testbench
	output logic                  data      // low = pressed
);

	logic [7:0] snap = '0;    // parallel-load copy of the buttons
	logic [3:0] idx  = 4'd8;  // button on the pin, 8 = past the end

	// transparent load while latch is high
	always @(latch or buttons)
	begin
		if (latch)
			snap = buttons;
	end

	// latch rewinds to button A, each rising nes_clk moves one on
	always @(posedge nes_clk or posedge latch)
	begin
		if (latch)
			idx <= 4'd0;
		else if (idx != 4'd8)
			idx <= idx + 1'b1;
	end

	assign data = (idx < 4'd8) ? ~snap[idx[2:0]] : 1'b1;  // pad pulls low when pressed

endmodule

// File: verilog/nes_pad_top.sv
// one NES pad in, release events out over req/ack; no press events, no auto-repeat
`include "nes_pad_config.svh"

module nes_pad_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        data,
	output logic                        latch,
	output logic                        nes_clk,
	output nes_pad_pkg::buttons_t       buttons,
	output logic                        req,
	output nes_pad_pkg::release_event_t evt,
	input  logic                        ack
);

	logic                                              frame_done;
	logic                                              armed;
	logic [`NES_NUM_BUTTONS-1:0]                       btn_vec;   // buttons as a plain vector
	logic [`NES_NUM_BUTTONS-1:0]                       pending;
	logic [`NES_NUM_BUTTONS-1:0]                       grant;
	nes_pad_pkg::release_event_t [`NES_NUM_BUTTONS-1:0] events;

	assign btn_vec = buttons;  // bit i is button i

	nes_pad_scanner u_scanner (
		.clk        (clk),
		.reset      (reset),
		.data       (data),
		.latch      (latch),
		.nes_clk    (nes_clk),
		.buttons    (buttons),
		.frame_done (frame_done),
		.armed      (armed)
	);

	// one tracker per button
	for (genvar i = 0; i < `NES_NUM_BUTTONS; i++)
	begin : g_trk
		button_release_tracker #(
			.BUTTON (nes_pad_pkg::button_idx_t'(i))
		) u_trk (
			.clk        (clk),
			.reset      (reset),
			.pressed    (btn_vec[i]),
			.frame_done (frame_done),
			.armed      (armed),
			.grant      (grant[i]),
			.pending    (pending[i]),
			.evt        (events[i])
		);
	end

	release_event_queue u_queue (
		.clk     (clk),
		.reset   (reset),
		.pending (pending),
		.events  (events),
		.grant   (grant),
		.req     (req),
		.ack     (ack),
		.evt     (evt)
	);

endmodule

// File: verilog/release_event_queue.sv
// lowest button number wins; host must follow the full four-phase req/ack handshake
`include "nes_pad_config.svh"

module release_event_queue (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic [`NES_NUM_BUTTONS-1:0]                       pending,
	input  nes_pad_pkg::release_event_t [`NES_NUM_BUTTONS-1:0] events,
	output logic [`NES_NUM_BUTTONS-1:0]                       grant,    // one-hot or zero
	output logic                                              req,
	input  logic                                              ack,
	output nes_pad_pkg::release_event_t                       evt      // valid while req
);

	typedef enum logic [1:0] {
		st_idle,      // free, may grant
		st_req,       // req high, waiting for ack
		st_ack_low    // req dropped, waiting for ack to fall
	} state_t;

	state_t                            state;
	logic [`NES_NUM_BUTTONS-1:0]       pick;      // lowest pending bit
	nes_pad_pkg::release_event_t       pick_evt;
	logic                              take;

	assign pick  = pending & (~pending + 1'b1);  // isolate lowest set bit
	assign take  = (state == st_idle) && !ack && (pending != '0);
	assign grant = take ? pick : '0;
	assign req   = (state == st_req);

	// walk down so the lowest pending index is the last one kept
	always_comb
	begin
		pick_evt = events[0];
		for (int i = `NES_NUM_BUTTONS - 1; i >= 0; i--)
		begin
			if (pending[i])
				pick_evt = events[i];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:
					if (take)
						state <= st_req;  // req up one cycle after grant
				st_req:
					if (ack)
						state <= st_ack_low;
				st_ack_low:
					if (!ack)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// copy of the granted event, tracker is free again after grant
	always_ff @(posedge clk)
	begin
		if (take)
			evt <= pick_evt;
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

	// host may sample evt any time before it acks
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		req && !ack |=> req && $stable(evt));

endmodule

// File: verilog/button_release_tracker.sv
// one button; a release that lands while the previous event is still pending is dropped
`include "nes_pad_config.svh"

module button_release_tracker #(
	parameter nes_pad_pkg::button_idx_t BUTTON = '0  // number written into the event
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        pressed,     // this button's field of buttons
	input  logic                        frame_done,
	input  logic                        armed,
	input  logic                        grant,       // one cycle, from the queue
	output logic                        pending,
	output nes_pad_pkg::release_event_t evt
);

	localparam logic [`NES_HOLD_BITS-1:0] hold_max = '1;

	logic [`NES_HOLD_BITS-1:0] hold;     // frames held so far
	logic                      tick;     // frame boundary that counts
	logic                      release_seen;

	assign tick         = frame_done && armed;
	assign release_seen = tick && !pressed && (hold != '0);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			hold    <= '0;
			pending <= 1'b0;
		end
		else
		begin
			if (tick && pressed && (hold != hold_max))  // saturate on long holds
				hold <= hold + 1'b1;
			else if (release_seen)  // count cleared even if the event is dropped
				hold <= '0;
			if (grant)
				pending <= 1'b0;
			else if (release_seen)
				pending <= 1'b1;
		end
	end

	// event register only loads when the slot is free
	always_ff @(posedge clk)
	begin
		if (release_seen && !pending)
		begin
			evt.button <= BUTTON;
			evt.hold   <= hold;  // count before clearing
		end
	end

	// queue must only pick a tracker that has something
	a_grant_pending: assert property (@(posedge clk) disable iff (reset)
		grant |-> pending);

endmodule

// File: verilog/nes_pad_scanner.sv
// single pad only; first frame after reset has a latch one cycle short and is never tracked
`include "nes_pad_config.svh"

module nes_pad_scanner (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  data,        // pad serial out, low = pressed
	output logic                  latch,
	output logic                  nes_clk,
	output nes_pad_pkg::buttons_t buttons,     // active high, updated once per frame
	output logic                  frame_done,  // one cycle, same edge as buttons
	output logic                  armed
);

	localparam int arm_bits = $clog2(`NES_ARM_FRAMES + 1);
	localparam logic [`NES_CNT_BITS-1:0] latch_last = `NES_LATCH_CYCLES - 1;
	localparam logic [`NES_CNT_BITS-1:0] half_cnt = `NES_HALF_BIT_CYCLES;
	localparam logic [`NES_CNT_BITS-1:0] half_last = `NES_HALF_BIT_CYCLES - 1;
	localparam logic [`NES_CNT_BITS-1:0] period_last = 2 * `NES_HALF_BIT_CYCLES - 1;
	localparam logic [arm_bits-1:0] arm_last = `NES_ARM_FRAMES - 1;

	typedef enum logic [1:0] {
		st_latch,  // latch high
		st_first,  // latch low, waiting to sample A
		st_bits    // clocking out B..right
	} state_t;

	state_t                   state, state_n;
	logic [`NES_CNT_BITS-1:0] cnt, cnt_n;          // cycles within the current phase
	logic [2:0]               bit_cnt, bit_cnt_n;  // button being clocked
	logic                     sample;              // take data this cycle
	logic                     frame_end;
	logic [7:0]               staging;             // fills from the msb end
	logic [arm_bits-1:0]      arm_cnt;             // frames seen before arming

	always_comb
	begin
		state_n   = state;
		cnt_n     = cnt + 1'b1;
		bit_cnt_n = bit_cnt;
		sample    = 1'b0;
		frame_end = 1'b0;
		case (state)
			st_latch:
			begin
				if (cnt == latch_last)
				begin
					state_n = st_first;
					cnt_n   = '0;
				end
			end
			st_first:
			begin
				if (cnt == half_last)  // A is already on data
				begin
					sample    = 1'b1;
					state_n   = st_bits;
					cnt_n     = '0;
					bit_cnt_n = 3'd1;
				end
			end
			st_bits:
			begin
				if (cnt == half_last)  // last high cycle, nes_clk falls next
					sample = 1'b1;
				if (cnt == period_last)
				begin
					cnt_n = '0;
					if (bit_cnt == 3'd7)  // right done, new latch right away
					begin
						frame_end = 1'b1;
						state_n   = st_latch;
						bit_cnt_n = '0;
					end
					else
						bit_cnt_n = bit_cnt + 1'b1;
				end
			end
			default:
			begin
				state_n = st_latch;
				cnt_n   = '0;
			end
		endcase
	end

	// pins are registered from the next state so they line up with state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= st_latch;
			cnt        <= '0;
			bit_cnt    <= '0;
			latch      <= 1'b0;
			nes_clk    <= 1'b0;
			frame_done <= 1'b0;
			buttons    <= '0;
		end
		else
		begin
			state      <= state_n;
			cnt        <= cnt_n;
			bit_cnt    <= bit_cnt_n;
			latch      <= (state_n == st_latch);
			nes_clk    <= (state_n == st_bits) && (cnt_n < half_cnt);  // high half first
			frame_done <= frame_end;
			if (frame_end)
				buttons <= nes_pad_pkg::buttons_t'(staging);
		end
	end

	// pad drives low for pressed, so invert on the way in
	always_ff @(posedge clk)
	begin
		if (sample)
			staging <= {~data, staging[7:1]};  // A ends up at bit 0
	end

	// armed rises the cycle after the last ignored frame_done, so that frame is not tracked
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			arm_cnt <= '0;
			armed   <= 1'b0;
		end
		else if (frame_done && !armed)
		begin
			if (arm_cnt == arm_last)
				armed <= 1'b1;
			else
				arm_cnt <= arm_cnt + 1'b1;
		end
	end

	// the pad would see a shift during latch
	a_latch_clk_excl: assert property (@(posedge clk) disable iff (reset)
		!(latch && nes_clk));

endmodule

// File: verilog/nes_pad_pkg.sv
// shared types for the pad reader; hold width comes from the config header
`include "nes_pad_config.svh"

package nes_pad_pkg;

	// button number, A=0 B=1 select=2 start=3 up=4 down=5 left=6 right=7
	typedef logic [2:0] button_idx_t;

	// one bit per button, 1 = pressed
	// first field is the msb, so a lands on bit 0 and right on bit 7
	typedef struct packed {
		logic right;   // bit 7
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;       // bit 0, first bit shifted out of the pad
	} buttons_t;

	// one release, handed from a tracker to the queue and on to the host
	typedef struct packed {
		button_idx_t               button;  // which button was let go
		logic [`NES_HOLD_BITS-1:0] hold;    // frames it was held, saturating
	} release_event_t;

endpackage

// File: verilog/nes_pad_config.svh
// timing assumes a 50 MHz clk; all counters must be wide enough for the values below
`ifndef NES_PAD_CONFIG_SVH
`define NES_PAD_CONFIG_SVH

// pad timing, in clk cycles
`define NES_LATCH_CYCLES 600     // latch pulse, 12 us
`define NES_HALF_BIT_CYCLES 300  // half nes_clk period, 6 us, also wait before button A

// cycle counter width, must hold 2*NES_HALF_BIT_CYCLES-1 and NES_LATCH_CYCLES-1
`define NES_CNT_BITS 10

// complete frames ignored after reset
// the data line can float or glitch while the pad powers up
`define NES_ARM_FRAMES 2

// hold counter width in frames, saturates at all ones
`define NES_HOLD_BITS 8

// buttons on one pad
// the button struct and the generate loop both rely on this being 8
`define NES_NUM_BUTTONS 8

`endif
